// File: hdl/gshare_params.svh
/*
  size macros for the gshare predictor
  history and index width, pc width, checkpoint depth, tag and counter widths
*/

`ifndef GSHARE_PARAMS_SVH
`define GSHARE_PARAMS_SVH

// global history length, also the pht index width (256 entries)
`define GS_HIST_BITS 8

// fetch pc width
`define GS_PC_BITS 32

// in-flight prediction slots, same as the credit total
`define GS_CKPT_DEPTH 4

// tag names one checkpoint slot
`define GS_TAG_BITS 2

// statistics counters and config data
`define GS_CNT_BITS 16

`endif

// File: hdl/gsharePkg.sv
/*
  shared types of the gshare predictor
  mode and register address enums, fetch/execute structs, checkpoint slot
*/

`default_nettype none
`include "gshare_params.svh"

package gsharePkg;

  // how the index is formed and whether the table is used at all
  typedef enum logic [1:0] {
    PM_GSHARE,
    PM_BIMODAL,
    PM_STATIC_NT
  } predModeE;

  // register map of the config block
  typedef enum logic [1:0] {
    CFG_MODE,
    CFG_BRANCHES,
    CFG_MISSES
  } cfgAddrE;

  // fetch request, one branch pc
  typedef struct packed {
    logic                   valid;
    logic [`GS_PC_BITS-1:0] pc;
  } predReqT;

  // prediction back to fetch
  typedef struct packed {
    logic                    valid;
    logic                    taken;
    logic [`GS_TAG_BITS-1:0] tag;
  } predRespT;

  // outcome from execute, always for the oldest tag
  typedef struct packed {
    logic                    valid;
    logic [`GS_TAG_BITS-1:0] tag;
    logic                    taken;
  } resolveT;

  // one checkpoint slot
  // hist is the history before the predicted bit went in
  typedef struct packed {
    logic [`GS_HIST_BITS-1:0] hist;
    logic [`GS_HIST_BITS-1:0] idx;
    logic [1:0]               oldCnt;
    logic                     predTaken;
  } ckptEntryT;

  // host register access
  typedef struct packed {
    logic                    we;
    cfgAddrE                 addr;
    logic [`GS_CNT_BITS-1:0] wdata;
  } cfgReqT;

endpackage

`default_nettype wire

// File: hdl/phtRam.sv
/*
  pattern history table of 2-bit counters
  one registered read port, one write port, clear sweep after reset
*/

`default_nettype none
`include "gshare_params.svh"

module phtRam (
  input  logic                     clk,
  input  logic                     rstN,
  input  logic [`GS_HIST_BITS-1:0] rdIdx,
  input  logic                     rdEn,
  output logic [1:0]               rdData,
  input  logic                     wrEn,
  input  logic [`GS_HIST_BITS-1:0] wrIdx,
  input  logic [1:0]               wrData,
  output logic                     ready
);

  localparam int Entries = 1 << `GS_HIST_BITS;

  logic [1:0]               mem [Entries];
  logic [`GS_HIST_BITS-1:0] sweepIdx;

  // muxed write port, the sweep owns it until ready
  logic                     memWe;
  logic [`GS_HIST_BITS-1:0] memWIdx;
  logic [1:0]               memWData;

  always_comb begin
    if (!ready) begin
      memWe    = 1'b1;
      memWIdx  = sweepIdx;
      memWData = 2'b01;  // weakly not-taken
    end else begin
      memWe    = wrEn;
      memWIdx  = wrIdx;
      memWData = wrData;
    end
  end

  // sweep walks all entries once, 256 cycles
  always_ff @(posedge clk) begin
    if (!rstN) begin
      sweepIdx <= '0;
      ready    <= 1'b0;
    end else if (!ready) begin
      sweepIdx <= sweepIdx + 1'b1;
      if (sweepIdx == '1)
        ready <= 1'b1;
    end
  end

  // read-first: a same-index write lands after the old value is taken
  always_ff @(posedge clk) begin
    if (memWe)
      mem[memWIdx] <= memWData;
    if (rdEn)
      rdData <= mem[rdIdx];
  end

endmodule

`default_nettype wire

// File: hdl/ghrCheckpoint.sv
/*
  speculative global history and checkpoint fifo
  repair and squash on misprediction, credit return to fetch
*/

`default_nettype none
`include "gshare_params.svh"

module ghrCheckpoint import gsharePkg::*; (
  input  logic                     clk,
  input  logic                     rstN,
  input  logic                     push,
  input  ckptEntryT                pushEntry,
  output logic [`GS_TAG_BITS-1:0]  pushTag,
  output logic [`GS_HIST_BITS-1:0] ghr,
  input  logic                     pop,
  output ckptEntryT                popEntry,
  input  logic                     repair,
  input  logic                     actualTaken,
  input  logic                     tableReady,
  output logic [2:0]               creditReturn,
  output logic                     squash
);

  localparam int HB = `GS_HIST_BITS;

  logic [HB-1:0]           ghrQ;
  ckptEntryT               slots [`GS_CKPT_DEPTH];
  logic [`GS_TAG_BITS-1:0] wrPtr;
  logic [`GS_TAG_BITS-1:0] rdPtr;
  logic [2:0]              count;
  logic                    readyQ;
  logic                    flush;

  assign flush   = pop & repair;
  assign pushTag = wrPtr;

  // history seen by a request this cycle, includes a push in flight
  // predicted bit enters at the msb end
  assign ghr = push ? {pushEntry.predTaken, ghrQ[HB-1:1]} : ghrQ;

  // empty fifo: the entry being pushed is the oldest one
  assign popEntry = (count == '0) ? pushEntry : slots[rdPtr];

  //////////////////////////////////////////////////
  // history register
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstN)
      ghrQ <= '0;
    else if (flush)
      ghrQ <= {actualTaken, popEntry.hist[HB-1:1]};  // checkpoint plus real outcome
    else if (push)
      ghrQ <= ghr;
  end

  //////////////////////////////////////////////////
  // checkpoint fifo
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstN) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else if (flush) begin
      // drop every younger slot, next tag follows the resolved one
      rdPtr <= rdPtr + 1'b1;
      wrPtr <= rdPtr + 1'b1;
      count <= '0;
    end else begin
      if (push)
        wrPtr <= wrPtr + 1'b1;
      if (pop)
        rdPtr <= rdPtr + 1'b1;
      count <= count + {2'b0, push} - {2'b0, pop};
    end
  end

  always_ff @(posedge clk) begin
    if (push)
      slots[wrPtr] <= pushEntry;
  end

  //////////////////////////////////////////////////
  // credits and squash
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstN) begin
      readyQ       <= 1'b0;
      creditReturn <= '0;
      squash       <= 1'b0;
    end else begin
      readyQ <= tableReady;
      squash <= flush;
      if (tableReady && !readyQ)
        creditReturn <= 3'(`GS_CKPT_DEPTH);  // full grant once the table is clear
      else if (flush)
        creditReturn <= count + {2'b0, push};  // popped slot plus all younger
      else if (pop)
        creditReturn <= 3'd1;
      else
        creditReturn <= '0;
    end
  end

endmodule

`default_nettype wire

// File: hdl/predictorConfig.sv
/*
  predictor register block
  mode select, resolved and mispredicted event counters
*/

`default_nettype none
`include "gshare_params.svh"

module predictorConfig import gsharePkg::*; (
  input  logic                    clk,
  input  logic                    rstN,
  input  cfgReqT                  cfgReq,
  output logic [`GS_CNT_BITS-1:0] cfgRdata,
  output predModeE                mode,
  input  logic                    resolved,
  input  logic                    mispredicted
);

  localparam int CB = `GS_CNT_BITS;

  // index 0 counts resolved branches, index 1 mispredictions
  logic [CB-1:0] evtCnt [2];
  logic [1:0]    evtHit;
  logic [1:0]    evtClr;

  assign evtHit    = {mispredicted, resolved};
  assign evtClr[0] = cfgReq.we & (cfgReq.addr == CFG_BRANCHES);
  assign evtClr[1] = cfgReq.we & (cfgReq.addr == CFG_MISSES);

  always_ff @(posedge clk) begin
    if (!rstN)
      mode <= PM_GSHARE;
    else if (cfgReq.we && cfgReq.addr == CFG_MODE)
      mode <= predModeE'(cfgReq.wdata[1:0]);
  end

  // saturating, a write to the address clears and wins over an event
  always_ff @(posedge clk) begin
    for (int i = 0; i < 2; i++) begin
      if (!rstN)
        evtCnt[i] <= '0;
      else if (evtClr[i])
        evtCnt[i] <= '0;
      else if (evtHit[i] && evtCnt[i] != '1)
        evtCnt[i] <= evtCnt[i] + 1'b1;
    end
  end

  // read data one cycle after the address
  always_ff @(posedge clk) begin
    case (cfgReq.addr)
      CFG_MODE:     cfgRdata <= {{(CB-2){1'b0}}, mode};
      CFG_BRANCHES: cfgRdata <= evtCnt[0];
      CFG_MISSES:   cfgRdata <= evtCnt[1];
      default:      cfgRdata <= '0;
    endcase
  end

endmodule

`default_nettype wire

// File: hdl/gsharePredictor.sv
/*
  gshare direction predictor core
  index hashing, prediction response, counter update, misprediction detect
*/

`default_nettype none
`include "gshare_params.svh"

module gsharePredictor import gsharePkg::*; (
  input  logic       clk,
  input  logic       rstN,
  input  predModeE   mode,
  input  predReqT    predReq,
  output predRespT   predResp,
  input  resolveT    resolve,
  output logic [2:0] creditReturn,
  output logic       squash,
  output logic       resolved,
  output logic       mispredicted
);

  localparam int HB = `GS_HIST_BITS;

  logic [HB-1:0]           ghr;
  logic [HB-1:0]           reqHist;
  logic [HB-1:0]           reqIdx;
  logic                    stageValid;
  logic                    stageStatic;
  logic [HB-1:0]           stageHist;
  logic [HB-1:0]           stageIdx;
  logic                    dropQ;
  logic [1:0]              cnt;
  logic [1:0]              newCnt;
  logic                    predTaken;
  logic                    tableReady;
  logic [`GS_TAG_BITS-1:0] pushTag;
  logic [2:0]              ckptCredit;
  ckptEntryT               pushEntry;
  ckptEntryT               popEntry;

  //////////////////////////////////////////////////
  // request side
  //////////////////////////////////////////////////

  // bimodal drops the history, upper pc bit folded onto the lowest word bit
  assign reqHist = (mode == PM_BIMODAL) ? '0 : ghr;
  assign reqIdx  = reqHist ^ {predReq.pc[HB+1] ^ predReq.pc[1], predReq.pc[HB:2]};

  // request held for the table read, killed by a same-cycle misprediction
  always_ff @(posedge clk) begin
    if (!rstN) begin
      stageValid <= 1'b0;
      dropQ      <= 1'b0;
    end else begin
      stageValid <= predReq.valid & ~mispredicted;
      dropQ      <= predReq.valid & mispredicted;
    end
  end

  always_ff @(posedge clk) begin
    stageHist   <= ghr;
    stageIdx    <= reqIdx;
    stageStatic <= (mode == PM_STATIC_NT);
  end

  // counter msb, static mode never predicts taken
  assign predTaken = ~stageStatic & cnt[1];
  assign pushEntry = '{hist: stageHist, idx: stageIdx, oldCnt: cnt, predTaken: predTaken};
  assign predResp  = '{valid: stageValid, taken: predTaken, tag: pushTag};

  //////////////////////////////////////////////////
  // resolve side
  //////////////////////////////////////////////////

  assign resolved     = resolve.valid;
  assign mispredicted = resolve.valid & (resolve.taken != popEntry.predTaken);

  // 2-bit saturating update of the stored counter
  always_comb begin
    if (resolve.taken)
      newCnt = (popEntry.oldCnt == 2'b11) ? 2'b11 : popEntry.oldCnt + 1'b1;
    else
      newCnt = (popEntry.oldCnt == 2'b00) ? 2'b00 : popEntry.oldCnt - 1'b1;
  end

  // a request dropped with the misprediction gives its credit back too
  assign creditReturn = ckptCredit + {2'b0, dropQ};

  phtRam pht_i (
    .clk    (clk),
    .rstN   (rstN),
    .rdIdx  (reqIdx),
    .rdEn   (predReq.valid),
    .rdData (cnt),
    .wrEn   (resolve.valid & (mode != PM_STATIC_NT)),
    .wrIdx  (popEntry.idx),
    .wrData (newCnt),
    .ready  (tableReady)
  );

  ghrCheckpoint ckpt_i (
    .clk          (clk),
    .rstN         (rstN),
    .push         (stageValid),
    .pushEntry    (pushEntry),
    .pushTag      (pushTag),
    .ghr          (ghr),
    .pop          (resolve.valid),
    .popEntry     (popEntry),
    .repair       (mispredicted),
    .actualTaken  (resolve.taken),
    .tableReady   (tableReady),
    .creditReturn (ckptCredit),
    .squash       (squash)
  );

endmodule

`default_nettype wire

// File: hdl/gshareTop.sv
/*
  gshare predictor top level
  config block and predictor core
*/

`default_nettype none
`include "gshare_params.svh"

module gshareTop import gsharePkg::*; (
  input  logic                    clk,
  input  logic                    rstN,
  input  predReqT                 predReq,
  output predRespT                predResp,
  input  resolveT                 resolve,
  output logic [2:0]              creditReturn,
  output logic                    squash,
  input  cfgReqT                  cfgReq,
  output logic [`GS_CNT_BITS-1:0] cfgRdata
);

  predModeE mode;
  logic     resolved;
  logic     mispredicted;

  // mode goes down, resolve events come back up for the statistics
  predictorConfig cfg_i (
    .clk          (clk),
    .rstN         (rstN),
    .cfgReq       (cfgReq),
    .cfgRdata     (cfgRdata),
    .mode         (mode),
    .resolved     (resolved),
    .mispredicted (mispredicted)
  );

  gsharePredictor pred_i (
    .clk          (clk),
    .rstN         (rstN),
    .mode         (mode),
    .predReq      (predReq),
    .predResp     (predResp),
    .resolve      (resolve),
    .creditReturn (creditReturn),
    .squash       (squash),
    .resolved     (resolved),
    .mispredicted (mispredicted)
  );

endmodule

`default_nettype wire

// File: verif/gshare_checker.sv
/*
  protocol assertions on the gshare top level
  credit use, sweep grant, squash cause, response cause
*/

`default_nettype none

module gshare_checker import gsharePkg::*; (
  input logic       clk,
  input logic       rstN,
  input predReqT    predReq,
  input predRespT   predResp,
  input logic [2:0] creditReturn,
  input logic       squash,
  input logic       mispredicted
);

  timeunit 1ns;
  timeprecision 1ps;

  // credits held by fetch, and cycles since reset went away
  int credits;
  int sinceRst;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      credits  <= 0;
      sinceRst <= 0;
    end else begin
      credits <= credits + int'(creditReturn) - int'(predReq.valid);
      if (sinceRst < 1000)
        sinceRst <= sinceRst + 1;
    end
  end

  // a credit arriving this cycle may be spent at once
  noReqWithoutRoom: assert property (@(posedge clk) disable iff (!rstN)
    predReq.valid |-> (credits + int'(creditReturn)) > 0)
    else $error("request issued with no free checkpoint slot");

  // the table clear takes 256 cycles
  noCreditInSweep: assert property (@(posedge clk) disable iff (!rstN)
    sinceRst < 256 |-> creditReturn == 3'd0)
    else $error("credit returned before the table sweep ended");

  // the resolved slot always comes back with the squash
  squashCause: assert property (@(posedge clk) disable iff (!rstN)
    squash |-> $past(mispredicted) && creditReturn != 3'd0)
    else $error("squash without a mispredicting resolve and its credit");

  respCause: assert property (@(posedge clk) disable iff (!rstN)
    predResp.valid |-> $past(predReq.valid && !mispredicted))
    else $error("response without an unsquashed request");

endmodule

`default_nettype wire

// File: verif/gshareTb.sv
/*
  testbench for the gshare predictor top level
  row table applied in bursts, reference model of pht, history and checkpoints
  credit tracking from creditReturn, statistics readback
*/

`default_nettype none
`include "gshare_params.svh"

module gshareTb import gsharePkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int HB      = `GS_HIST_BITS;
  localparam int NumRows = 16;
  localparam int Passes  = 3;

  typedef struct packed {
    predModeE               mode;
    logic [`GS_PC_BITS-1:0] pc;
    logic                   taken;
    logic                   boundary;  // burst ends after this row
  } rowT;

  // mode, pc, actual outcome, burst boundary
  localparam rowT Rows [NumRows] = '{
    '{PM_GSHARE,    32'h0000_1000, 1'b1, 1'b1},
    '{PM_GSHARE,    32'h0000_1004, 1'b1, 1'b1},
    '{PM_GSHARE,    32'h0000_1000, 1'b1, 1'b1},
    '{PM_GSHARE,    32'h0000_1008, 1'b0, 1'b1},
    '{PM_GSHARE,    32'h0000_1000, 1'b1, 1'b1},
    '{PM_GSHARE,    32'h0000_2000, 1'b1, 1'b0},
    '{PM_GSHARE,    32'h0000_2004, 1'b0, 1'b0},
    '{PM_GSHARE,    32'h0000_2008, 1'b1, 1'b0},
    '{PM_GSHARE,    32'h0000_200c, 1'b1, 1'b1},
    '{PM_GSHARE,    32'h0000_2000, 1'b1, 1'b0},
    '{PM_GSHARE,    32'h0000_2204, 1'b1, 1'b1},
    '{PM_BIMODAL,   32'h0000_3000, 1'b1, 1'b0},
    '{PM_BIMODAL,   32'h0000_3004, 1'b1, 1'b0},
    '{PM_BIMODAL,   32'h0000_3000, 1'b0, 1'b1},
    '{PM_STATIC_NT, 32'h0000_4000, 1'b1, 1'b0},
    '{PM_STATIC_NT, 32'h0000_4004, 1'b0, 1'b1}
  };

  logic                    clk = 1'b0;
  logic                    rstN;
  predReqT                 predReq;
  predRespT                predResp;
  resolveT                 resolve;
  logic [2:0]              creditReturn;
  logic                    squash;
  cfgReqT                  cfgReq;
  logic [`GS_CNT_BITS-1:0] cfgRdata;

  // reference model
  logic [1:0]              mPht [1 << HB];
  logic [HB-1:0]           mGhr;
  ckptEntryT               mQ [$];
  logic [`GS_TAG_BITS-1:0] mHeadTag;
  int                      mBranches;
  int                      mMisses;

  // what the sampler saw
  int         creditsIn;
  int         creditsSpent;
  logic [2:0] lastCredit;
  logic       lastSquash;
  predRespT   respQ [$];
  logic [31:0] rng;
  predModeE   curMode;

  always #50 clk = ~clk;

  gshareTop dut_i (
    .clk          (clk),
    .rstN         (rstN),
    .predReq      (predReq),
    .predResp     (predResp),
    .resolve      (resolve),
    .creditReturn (creditReturn),
    .squash       (squash),
    .cfgReq       (cfgReq),
    .cfgRdata     (cfgRdata)
  );

  // protocol assertions inside the top level
  bind gshareTop gshare_checker chk_i (
    .clk          (clk),
    .rstN         (rstN),
    .predReq      (predReq),
    .predResp     (predResp),
    .creditReturn (creditReturn),
    .squash       (squash),
    .mispredicted (mispredicted)
  );

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////

  function automatic logic [31:0] lcgNext(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // top pc bit folds onto the lowest word bit
  function automatic logic [HB-1:0] pcFold(input logic [`GS_PC_BITS-1:0] pc);
    return {pc[9] ^ pc[1], pc[8:2]};
  endfunction

  function automatic logic [1:0] satCount(input logic [1:0] c, input logic up);
    if (up)
      return (c == 2'b11) ? c : c + 2'b01;
    return (c == 2'b00) ? c : c - 2'b01;
  endfunction

  task automatic stopFail(input string why);
    $display("%s", why);
    $display("*** FAILED ***");
    $fatal(1);
  endtask

  task automatic checkVal(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp)
    else stopFail($sformatf("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp));
  endtask

  // sample mid-cycle, then on to the next rising edge
  task automatic clockStep();
    @(negedge clk);
    creditsIn += int'(creditReturn);
    lastCredit = creditReturn;
    lastSquash = squash;
    if (predResp.valid)
      respQ.push_back(predResp);
    @(posedge clk);
  endtask

  task automatic waitCredit(input int limit);
    int n;
    n = 0;
    while (creditsIn - creditsSpent <= 0) begin
      n++;
      if (n > limit)
        stopFail("timeout while waiting for a fetch credit");
      clockStep();
    end
  endtask

  // one request, history updated speculatively
  task automatic sendRequest(input rowT r);
    ckptEntryT e;
    waitCredit(8);
    e.hist      = mGhr;
    e.idx       = ((r.mode == PM_BIMODAL) ? {HB{1'b0}} : mGhr) ^ pcFold(r.pc);
    e.oldCnt    = mPht[e.idx];
    e.predTaken = (r.mode != PM_STATIC_NT) && mPht[e.idx][1];
    mQ.push_back(e);
    mGhr = {e.predTaken, mGhr[HB-1:1]};
    predReq <= '{valid: 1'b1, pc: r.pc};
    creditsSpent++;
    clockStep();
  endtask

  task automatic waitResponses(input int n);
    int k;
    k = 0;
    while (respQ.size() < n) begin
      k++;
      if (k > 8)
        stopFail("timeout while waiting for prediction responses");
      clockStep();
    end
  endtask

  task automatic checkBurst(input int n);
    logic [`GS_TAG_BITS-1:0] expTag;
    expTag = mHeadTag;
    checkVal("response count", respQ.size(), n);
    for (int i = 0; i < n; i++) begin
      checkVal("predResp.taken", 32'(respQ[i].taken), 32'(mQ[i].predTaken));
      checkVal("predResp.tag", 32'(respQ[i].tag), 32'(expTag));
      expTag++;
    end
  endtask

  // oldest entry resolves, a miss repairs history and drops the rest
  task automatic resolveOldest(input logic taken, output logic miss);
    ckptEntryT  e;
    logic [2:0] expCredit;
    e    = mQ.pop_front();
    miss = (taken != e.predTaken);
    resolve <= '{valid: 1'b1, tag: mHeadTag, taken: taken};
    if (curMode != PM_STATIC_NT)
      mPht[e.idx] = satCount(e.oldCnt, taken);
    mBranches++;
    mHeadTag++;
    expCredit = 3'd1;
    if (miss) begin
      mMisses++;
      expCredit = 3'(1 + mQ.size());
      mQ.delete();
      mGhr = {taken, e.hist[HB-1:1]};
    end
    clockStep();
    resolve.valid <= 1'b0;
    clockStep();
    checkVal("creditReturn", 32'(lastCredit), 32'(expCredit));
    checkVal("squash", 32'(lastSquash), 32'(miss));
  endtask

  task automatic cfgWrite(input cfgAddrE addr, input logic [15:0] data);
    cfgReq <= '{we: 1'b1, addr: addr, wdata: data};
    clockStep();
    cfgReq.we <= 1'b0;
    clockStep();
  endtask

  // read data follows the address by one cycle
  task automatic cfgCheck(input cfgAddrE addr, input string name, input int exp);
    cfgReq <= '{we: 1'b0, addr: addr, wdata: '0};
    clockStep();
    clockStep();
    checkVal(name, 32'(cfgRdata), exp);
  endtask

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////

  initial begin
    int   row;
    int   n;
    int   k;
    int   maxLen;
    int   waited;
    logic miss;
    rstN    = 1'b0;
    predReq = '0;
    resolve = '0;
    cfgReq  = '0;
    for (int i = 0; i < (1 << HB); i++)
      mPht[i] = 2'b01;
    mGhr      = '0;
    mHeadTag  = '0;
    mBranches = 0;
    mMisses   = 0;
    creditsIn    = 0;
    creditsSpent = 0;
    rng     = 32'h36ad_5ddd;
    curMode = PM_GSHARE;
    repeat (8) @(posedge clk);
    rstN <= 1'b1;

    // nothing until the 256-cycle table clear is done, then the full grant
    waited = 0;
    while (creditsIn == 0) begin
      waited++;
      if (waited > 400)
        stopFail("timeout while waiting for the initial credit grant");
      clockStep();
    end
    assert (waited > 256)
    else stopFail("credits arrived before the table clear sweep ended");
    repeat (3) clockStep();
    checkVal("credit grant", creditsIn, `GS_CKPT_DEPTH);

    for (int pass = 0; pass < Passes; pass++) begin
      row = 0;
      while (row < NumRows) begin
        if (Rows[row].mode != curMode) begin
          cfgWrite(CFG_MODE, 16'(Rows[row].mode));
          curMode = Rows[row].mode;
        end
        // burst length from the lcg, cut at a boundary or a mode change
        rng    = lcgNext(rng);
        maxLen = int'(rng[17:16]) + 1;
        n      = 0;
        while (n < maxLen && row + n < NumRows && Rows[row + n].mode == curMode) begin
          n++;
          if (Rows[row + n - 1].boundary)
            break;
        end
        respQ.delete();
        for (int i = 0; i < n; i++)
          sendRequest(Rows[row + i]);
        predReq.valid <= 1'b0;
        waitResponses(n);
        if (pass == 0 && row == 0)
          checkVal("first predResp.taken", 32'(respQ[0].taken), 32'd0);
        checkBurst(n);
        // squashed rows after a miss are issued again next burst
        k    = 0;
        miss = 1'b0;
        while (k < n && !miss) begin
          resolveOldest(Rows[row + k].taken, miss);
          k++;
        end
        row += k;
      end
    end

    cfgCheck(CFG_BRANCHES, "cfgRdata branches", mBranches);
    cfgCheck(CFG_MISSES, "cfgRdata misses", mMisses);
    $display("*** PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+hdl
hdl/gsharePkg.sv
hdl/phtRam.sv
hdl/ghrCheckpoint.sv
hdl/predictorConfig.sv
hdl/gsharePredictor.sv
hdl/gshareTop.sv
verif/gshare_checker.sv
verif/gshareTb.sv

// File: Makefile
# Verilator build for the gshare predictor testbench

VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal -j 0
TOP       ?= gshareTb
FILELIST  ?= verilog.f
OBJDIR    ?= obj_dir

SIM     := $(OBJDIR)/V$(TOP)
SOURCES := $(wildcard hdl/*.sv hdl/*.svh verif/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# a $fatal or a failed assertion gives a non-zero exit status
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJDIR)
